// ==== hdl/mask_ram_cfg_pkg.sv ====
package mask_ram_cfg_pkg;

  // Default data width in bits for one memory word
  localparam int DEF_WIDTH_P = 32;

  // Default number of words held by the memory
  localparam int DEF_ELS_P = 64;

  // Address width that goes with the default depth
  localparam int DEF_ADDR_WIDTH = $clog2(DEF_ELS_P);

  // A data word in the default configuration
  typedef logic [DEF_WIDTH_P-1:0] word_t;

  // A per-bit write mask in the default configuration
  // A set bit means the matching data bit is written
  typedef logic [DEF_WIDTH_P-1:0] mask_t;

  // A word address in the default configuration
  typedef logic [DEF_ADDR_WIDTH-1:0] addr_t;

endpackage

// ==== hdl/mask_ram_op_pkg.sv ====
package mask_ram_op_pkg;

  // Request operation as it arrives on the command port
  typedef logic [1:0] op_t;

  // Plain read of one word
  localparam op_t OP_READ = 2'd0;

  // Write of the data word under the bit mask of the request
  localparam op_t OP_WRITE = 2'd1;

  // Set every bit that is one in the data word
  localparam op_t OP_SET_BITS = 2'd2;

  // Clear every bit that is one in the data word
  localparam op_t OP_CLEAR_BITS = 2'd3;

  // Whether a merged write is waiting for its commit to the array
  // PEND_IDLE means the array already holds the current value of every word
  // PEND_HELD means the word at the last address still has to be written back
  typedef enum logic {
    PEND_IDLE = 1'b0,
    PEND_HELD = 1'b1
  } pend_state_t;

endpackage

// ==== hdl/mask_ram_req_decode.sv ====
`timescale 1ns/1ps

module mask_ram_req_decode import mask_ram_op_pkg::*; #(
  parameter int width_p = 32,
  parameter int els_p = 64,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     cmd_v_i,
  input  op_t                      cmd_op_i,
  input  logic [addr_width_lp-1:0] cmd_addr_i,
  input  logic [width_p-1:0]       cmd_data_i,
  input  logic [width_p-1:0]       cmd_mask_i,

  output logic                     req_v_o,
  output logic                     req_w_o,
  output logic [addr_width_lp-1:0] req_addr_o,
  output logic [width_p-1:0]       req_data_o,
  output logic [width_p-1:0]       req_mask_o
);

  typedef logic [width_p-1:0] word_t;

  logic  req_w_n;
  word_t req_data_n;
  word_t req_mask_n;

  // Every operation becomes either a read or a masked write
  // Set and clear use the command data as the mask of bits to touch
  always_comb begin
    req_w_n    = 1'b1;
    req_data_n = cmd_data_i;
    req_mask_n = cmd_mask_i;
    case (cmd_op_i)
      OP_READ: begin
        req_w_n    = 1'b0;
        req_data_n = '0;
        req_mask_n = '0;
      end
      OP_SET_BITS: begin
        req_data_n = '1;
        req_mask_n = cmd_data_i;
      end
      OP_CLEAR_BITS: begin
        req_data_n = '0;
        req_mask_n = cmd_data_i;
      end
      default: begin
        // OP_WRITE keeps data and mask as given
      end
    endcase
  end

  // The strobe is the only control bit here
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_v_o <= 1'b0;
    end else begin
      req_v_o <= cmd_v_i;
    end
  end

  // Payload is loaded only with a request and is read only under req_v_o
  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      req_w_o    <= req_w_n;
      req_addr_o <= cmd_addr_i;
      req_data_o <= req_data_n;
      req_mask_o <= req_mask_n;
    end
  end

  // An address past the last word would alias onto another word in the array
  a_addr_in_range : assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i |-> (int'(cmd_addr_i) < els_p));

endmodule

// ==== hdl/mask_ram_rmw_ctrl.sv ====
`timescale 1ns/1ps

module mask_ram_rmw_ctrl import mask_ram_op_pkg::*; #(
  parameter int width_p = 32,
  parameter int els_p = 64,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     req_v_i,
  input  logic                     req_w_i,
  input  logic [addr_width_lp-1:0] req_addr_i,
  input  logic [width_p-1:0]       req_data_i,
  input  logic [width_p-1:0]       req_mask_i,

  input  logic [width_p-1:0]       ram_r_data_i,
  output logic                     ram_r_en_o,
  output logic [addr_width_lp-1:0] ram_r_addr_o,
  output logic                     ram_w_en_o,
  output logic [addr_width_lp-1:0] ram_w_addr_o,
  output logic [width_p-1:0]       ram_w_data_o,

  output logic                     rd_v_o,
  output logic                     rd_is_w_o,
  output logic [width_p-1:0]       rd_data_o
);

  typedef logic [width_p-1:0] word_t;
  typedef logic [addr_width_lp-1:0] addr_t;

  // State of the last accepted request
  addr_t       addr_r;
  word_t       w_data_r;
  word_t       w_mask_r;
  logic        w_r;
  logic        last_v_r;
  pend_state_t pend_r;

  // Read register and its source select
  // When src_ram_r is set the array output holds the current word
  word_t       r_data_r;
  logic        src_ram_r;
  logic        rd_v_r;

  word_t       cur_word;
  word_t       merged_word;
  logic        same_addr;
  logic        masked;
  logic        r_en;
  logic        w_en;

  // The array keeps its read output until the next read, so no copy is needed
  assign cur_word = src_ram_r ? ram_r_data_i : r_data_r;

  // Old word with the pending write data laid over its masked bits
  assign merged_word = (cur_word & ~w_mask_r) | (w_data_r & w_mask_r);

  // No address is remembered right after reset
  assign same_addr = last_v_r && (addr_r == req_addr_i);

  // A write with a full mask does not need the old word
  assign masked = req_w_i && (req_mask_i != '1);

  // Reads and partial writes to a new address fetch the old word
  assign r_en = req_v_i && (masked || !req_w_i) && !same_addr;

  // The pending word is written back once a different address shows up
  assign w_en = req_v_i && !same_addr && (pend_r == PEND_HELD);

  assign ram_r_en_o   = r_en;
  assign ram_r_addr_o = req_addr_i;
  assign ram_w_en_o   = w_en;
  assign ram_w_addr_o = addr_r;
  assign ram_w_data_o = merged_word;

  assign rd_v_o    = rd_v_r;
  assign rd_is_w_o = w_r;
  assign rd_data_o = cur_word;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_v_r  <= 1'b0;
      w_r       <= 1'b0;
      pend_r    <= PEND_IDLE;
      rd_v_r    <= 1'b0;
      r_data_r  <= '0;
      src_ram_r <= 1'b0;
    end else begin
      rd_v_r <= req_v_i && !req_w_i;
      if (req_v_i) begin
        last_v_r <= 1'b1;
        w_r      <= req_w_i;
        // A same-address request keeps a held write alive
        if (req_w_i || (same_addr && pend_r == PEND_HELD)) begin
          pend_r <= PEND_HELD;
        end else begin
          pend_r <= PEND_IDLE;
        end
      end
      // Same-address bypass folds the earlier write into the read register
      if (r_en) begin
        src_ram_r <= 1'b1;
      end else if (req_v_i && w_r && same_addr) begin
        r_data_r  <= merged_word;
        src_ram_r <= 1'b0;
      end
    end
  end

  // A read clears the mask since any earlier write is already folded in
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      addr_r   <= req_addr_i;
      w_data_r <= req_w_i ? req_data_i : '0;
      w_mask_r <= req_w_i ? req_mask_i : '0;
    end
  end

  // The fetch always targets a new address while the commit targets the old one
  a_no_rw_collision : assert property (@(posedge clk_i) disable iff (reset_i)
    (ram_r_en_o && ram_w_en_o) |-> (ram_r_addr_o != ram_w_addr_o));

  // A write that was accepted last stays held until another address commits it
  a_write_held : assert property (@(posedge clk_i) disable iff (reset_i)
    w_r |-> (pend_r == PEND_HELD));

endmodule

// ==== hdl/mask_ram_array.sv ====
`timescale 1ns/1ps

module mask_ram_array #(
  parameter int width_p = 32,
  parameter int els_p = 64,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic                     clk_i,

  input  logic                     r_en_i,
  input  logic [addr_width_lp-1:0] r_addr_i,
  output logic [width_p-1:0]       r_data_o,

  input  logic                     w_en_i,
  input  logic [addr_width_lp-1:0] w_addr_i,
  input  logic [width_p-1:0]       w_data_i
);

  typedef logic [width_p-1:0] word_t;

  // Storage starts out as all zeros and is never touched by reset
  word_t mem [els_p] = '{default: '0};

  word_t r_data_r;

  // One write port and one registered read port map onto block RAM
  // The read output holds its value on cycles without a read
  always_ff @(posedge clk_i) begin
    if (w_en_i) begin
      mem[w_addr_i] <= w_data_i;
    end
    if (r_en_i) begin
      r_data_r <= mem[r_addr_i];
    end
  end

  assign r_data_o = r_data_r;

endmodule

// ==== hdl/mask_ram_read_hold.sv ====
`timescale 1ns/1ps

module mask_ram_read_hold #(
  parameter int width_p = 32,
  parameter bit latch_last_read_p = 1'b0
) (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               rd_v_i,
  input  logic               rd_is_w_i,
  input  logic [width_p-1:0] rd_data_i,

  output logic               rdata_v_o,
  output logic [width_p-1:0] rdata_o
);

  // The controller already registers the strobe one cycle after the read
  assign rdata_v_o = rd_v_i;

  if (latch_last_read_p) begin : g_latch
    logic [width_p-1:0] held_r;

    // Capture follows the read register while the last request was a read
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        held_r <= '0;
      end else if (!rd_is_w_i) begin
        held_r <= rd_data_i;
      end
    end

    // Writes may change the read register through the bypass
    // so the output shows the held word while a write is the last request
    assign rdata_o = rd_is_w_i ? held_r : rd_data_i;
  end else begin : g_pass
    // Without holding the read register goes straight out
    assign rdata_o = rd_data_i;
  end

endmodule

// ==== hdl/mask_ram_top.sv ====
`timescale 1ns/1ps

module mask_ram_top import mask_ram_cfg_pkg::*, mask_ram_op_pkg::*; #(
  parameter int width_p = DEF_WIDTH_P,
  parameter int els_p = DEF_ELS_P,
  parameter bit latch_last_read_p = 1'b0,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     cmd_v_i,
  input  op_t                      cmd_op_i,
  input  logic [addr_width_lp-1:0] cmd_addr_i,
  input  logic [width_p-1:0]       cmd_data_i,
  input  logic [width_p-1:0]       cmd_mask_i,

  output logic                     rdata_v_o,
  output logic [width_p-1:0]       rdata_o
);

  // Registered request in masked-write form
  logic                     req_v;
  logic                     req_w;
  logic [addr_width_lp-1:0] req_addr;
  logic [width_p-1:0]       req_data;
  logic [width_p-1:0]       req_mask;

  // Array ports
  logic                     ram_r_en;
  logic [addr_width_lp-1:0] ram_r_addr;
  logic [width_p-1:0]       ram_r_data;
  logic                     ram_w_en;
  logic [addr_width_lp-1:0] ram_w_addr;
  logic [width_p-1:0]       ram_w_data;

  // Read result towards the output stage
  logic                     rd_v;
  logic                     rd_is_w;
  logic [width_p-1:0]       rd_data;

  mask_ram_req_decode #(
    .width_p(width_p),
    .els_p  (els_p)
  ) u_decode (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cmd_v_i   (cmd_v_i),
    .cmd_op_i  (cmd_op_i),
    .cmd_addr_i(cmd_addr_i),
    .cmd_data_i(cmd_data_i),
    .cmd_mask_i(cmd_mask_i),
    .req_v_o   (req_v),
    .req_w_o   (req_w),
    .req_addr_o(req_addr),
    .req_data_o(req_data),
    .req_mask_o(req_mask)
  );

  mask_ram_rmw_ctrl #(
    .width_p(width_p),
    .els_p  (els_p)
  ) u_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v),
    .req_w_i     (req_w),
    .req_addr_i  (req_addr),
    .req_data_i  (req_data),
    .req_mask_i  (req_mask),
    .ram_r_data_i(ram_r_data),
    .ram_r_en_o  (ram_r_en),
    .ram_r_addr_o(ram_r_addr),
    .ram_w_en_o  (ram_w_en),
    .ram_w_addr_o(ram_w_addr),
    .ram_w_data_o(ram_w_data),
    .rd_v_o      (rd_v),
    .rd_is_w_o   (rd_is_w),
    .rd_data_o   (rd_data)
  );

  mask_ram_array #(
    .width_p(width_p),
    .els_p  (els_p)
  ) u_array (
    .clk_i   (clk_i),
    .r_en_i  (ram_r_en),
    .r_addr_i(ram_r_addr),
    .r_data_o(ram_r_data),
    .w_en_i  (ram_w_en),
    .w_addr_i(ram_w_addr),
    .w_data_i(ram_w_data)
  );

  mask_ram_read_hold #(
    .width_p          (width_p),
    .latch_last_read_p(latch_last_read_p)
  ) u_hold (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .rd_v_i   (rd_v),
    .rd_is_w_i(rd_is_w),
    .rd_data_i(rd_data),
    .rdata_v_o(rdata_v_o),
    .rdata_o  (rdata_o)
  );

endmodule

// ==== tb/mask_ram_tb.sv ====
`timescale 1ns/1ps

module mask_ram_tb import mask_ram_cfg_pkg::*, mask_ram_op_pkg::*; ();

  localparam int RAND_OPS = 200;
  // Rough length of all directed tests together, in clock cycles
  localparam int DIRECTED_CYCLES = 150;
  localparam int TIMEOUT_CYCLES = 2 * (DIRECTED_CYCLES + RAND_OPS);
  localparam int READ_WAIT_LIMIT = 10;
  localparam int READ_LATENCY = 2;

  logic  clk_i;
  logic  reset_i;
  logic  cmd_v_i;
  op_t   cmd_op_i;
  addr_t cmd_addr_i;
  word_t cmd_data_i;
  mask_t cmd_mask_i;
  logic  rdata_v_o;
  word_t rdata_o;

  // Reference copy of the memory, updated in request order
  word_t model [DEF_ELS_P] = '{default: '0};

  // Expected read words and the cycle each read was issued in
  word_t exp_q [$];
  int    issue_q [$];

  word_t  last_rdata;
  word_t  exp_word;
  int     issue_at;
  int     neg_cnt = 0;
  int     cycle_cnt = 0;
  int     check_cnt = 0;
  int     error_cnt = 0;
  int     read_cnt = 0;
  integer seed;

  mask_ram_top #(
    .width_p          (DEF_WIDTH_P),
    .els_p            (DEF_ELS_P),
    .latch_last_read_p(1'b1)
  ) u_dut (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cmd_v_i   (cmd_v_i),
    .cmd_op_i  (cmd_op_i),
    .cmd_addr_i(cmd_addr_i),
    .cmd_data_i(cmd_data_i),
    .cmd_mask_i(cmd_mask_i),
    .rdata_v_o (rdata_v_o),
    .rdata_o   (rdata_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    if (act !== exp) begin
      error_cnt++;
      $display("FAIL %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
    end
  endtask

  // Each operation is a masked write rule on the stored word
  task automatic apply_model(input op_t op, input addr_t addr, input word_t data,
                             input mask_t mask);
    case (op)
      OP_WRITE:      model[addr] = (model[addr] & ~mask) | (data & mask);
      OP_SET_BITS:   model[addr] = model[addr] | data;
      OP_CLEAR_BITS: model[addr] = model[addr] & ~data;
      default: begin
        exp_q.push_back(model[addr]);
        issue_q.push_back(neg_cnt);
      end
    endcase
  endtask

  // Inputs and outputs are stable at the falling edge
  // Responses are matched first, then the request of this cycle enters the model
  always @(negedge clk_i) begin
    neg_cnt++;
    if (!reset_i) begin
      if (rdata_v_o) begin
        if (exp_q.size() == 0) begin
          error_cnt++;
          $display("Read strobe at %0t arrived with no read outstanding", $time);
        end else begin
          exp_word = exp_q.pop_front();
          issue_at = issue_q.pop_front();
          read_cnt++;
          last_rdata = rdata_o;
          check_val("rdata_o", exp_word, rdata_o);
          check_val("rdata_v_o delay", READ_LATENCY, neg_cnt - issue_at);
        end
      end
      if (cmd_v_i) begin
        apply_model(cmd_op_i, cmd_addr_i, cmd_data_i, cmd_mask_i);
      end
    end
  end

  // Watchdog over the whole run
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Run stopped because the tests did not finish in %0d cycles", TIMEOUT_CYCLES);
      $display("Summary: %0d checks, %0d reads, %0d errors", check_cnt, read_cnt, error_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Request stays on the bus until the next edge drives something else
  task automatic send(input op_t op, input addr_t addr, input word_t data, input mask_t mask);
    @(posedge clk_i);
    cmd_v_i    <= 1'b1;
    cmd_op_i   <= op;
    cmd_addr_i <= addr;
    cmd_data_i <= data;
    cmd_mask_i <= mask;
  endtask

  // Drops the strobe and waits until every issued read has been answered
  task automatic wait_reads_done();
    int n;
    n = 0;
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
    while (exp_q.size() != 0 && n < READ_WAIT_LIMIT) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      error_cnt++;
      $display("Read response missing %0d cycles after the last request", n);
      exp_q.delete();
      issue_q.delete();
    end
  endtask

  task automatic read_word(input addr_t addr, output word_t data);
    send(OP_READ, addr, '0, '0);
    wait_reads_done();
    data = last_rdata;
  endtask

  task automatic test_reset_state();
    word_t data;
    repeat (4) begin
      @(negedge clk_i);
      check_val("rdata_v_o", 1'b0, rdata_v_o);
    end
    read_word(6'd0, data);
    check_val("rdata_o", '0, data);
    read_word(6'd17, data);
    check_val("rdata_o", '0, data);
    read_word(6'd63, data);
    check_val("rdata_o", '0, data);
  endtask

  task automatic test_write_read_back();
    word_t data;
    send(OP_WRITE, 6'd3, 32'hdead_beef, '1);
    read_word(6'd40, data);
    check_val("rdata_o", '0, data);
    read_word(6'd3, data);
    check_val("rdata_o", 32'hdead_beef, data);
  endtask

  // Expected words follow from the base word by hand
  task automatic test_masked_ops();
    word_t data;
    send(OP_WRITE, 6'd9, 32'ha5a5_0f0f, '1);
    send(OP_WRITE, 6'd9, 32'h1234_5678, 32'h00ff_ff00);
    read_word(6'd9, data);
    check_val("rdata_o", 32'ha534_560f, data);
    send(OP_SET_BITS, 6'd9, 32'h0000_00f0, '0);
    read_word(6'd9, data);
    check_val("rdata_o", 32'ha534_56ff, data);
    send(OP_CLEAR_BITS, 6'd9, 32'ha000_0003, '0);
    read_word(6'd9, data);
    check_val("rdata_o", 32'h0534_56fc, data);
  endtask

  task automatic test_same_addr_merge();
    word_t       data;
    pend_state_t pend_seen;
    send(OP_WRITE, 6'd20, 32'h1111_1111, '1);
    send(OP_WRITE, 6'd20, 32'h0000_00aa, 32'h0000_00ff);
    send(OP_WRITE, 6'd20, 32'h0000_bb00, 32'h0000_ff00);
    send(OP_SET_BITS, 6'd20, 32'h0f00_0000, '0);
    read_word(6'd20, data);
    check_val("rdata_o", 32'h1f11_bbaa, data);
    pend_seen = u_dut.u_ctrl.pend_r;
    $display("Controller write state after merged writes: %s", pend_seen.name());
    // Moving away commits the merged word so the re-read comes from the array
    read_word(6'd21, data);
    check_val("rdata_o", '0, data);
    read_word(6'd20, data);
    check_val("rdata_o", 32'h1f11_bbaa, data);
  endtask

  task automatic send_keeping_hold(input op_t op, input addr_t addr, input word_t data,
                                   input mask_t mask, input word_t held);
    send(op, addr, data, mask);
    @(negedge clk_i);
    check_val("rdata_o", held, rdata_o);
    check_val("rdata_v_o", 1'b0, rdata_v_o);
  endtask

  task automatic test_read_hold();
    word_t data;
    word_t held;
    // Word 9 still holds the result of the masked operations
    held = 32'h0534_56fc;
    read_word(6'd9, data);
    check_val("rdata_o", held, data);
    // Partial writes fetch other words through the array port
    send_keeping_hold(OP_WRITE, 6'd3, 32'h0f0f_0f0f, 32'h0000_ffff, held);
    send_keeping_hold(OP_WRITE, 6'd40, 32'hcafe_f00d, 32'hff00_00ff, held);
    send_keeping_hold(OP_SET_BITS, 6'd12, 32'h8000_0001, '0, held);
    send_keeping_hold(OP_WRITE, 6'd50, 32'h7654_3210, '1, held);
    repeat (3) begin
      @(posedge clk_i);
      cmd_v_i <= 1'b0;
      @(negedge clk_i);
      check_val("rdata_o", held, rdata_o);
      check_val("rdata_v_o", 1'b0, rdata_v_o);
    end
  endtask

  // One request per cycle while the monitor compares every read
  task automatic test_random_mix();
    op_t   op;
    addr_t addr;
    word_t data;
    mask_t mask;
    int    i;
    for (i = 0; i < RAND_OPS; i++) begin
      op   = op_t'($random(seed) & 3);
      addr = addr_t'($random(seed) & 15);
      data = word_t'($random(seed));
      if (($random(seed) & 3) == 0) begin
        mask = '1;
      end else begin
        mask = mask_t'($random(seed));
      end
      send(op, addr, data, mask);
    end
    wait_reads_done();
  endtask

  initial begin
    seed       = 32'h6b6416f6;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    cmd_v_i    = 1'b0;
    cmd_op_i   = OP_READ;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    cmd_mask_i = '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    test_reset_state();
    test_write_read_back();
    test_masked_ops();
    test_same_addr_merge();
    test_read_hold();
    test_random_mix();

    repeat (2) @(posedge clk_i);
    $display("Summary: %0d checks, %0d reads, %0d errors", check_cnt, read_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== mask_ram_top.f ====
hdl/mask_ram_cfg_pkg.sv
hdl/mask_ram_op_pkg.sv
hdl/mask_ram_req_decode.sv
hdl/mask_ram_rmw_ctrl.sv
hdl/mask_ram_array.sv
hdl/mask_ram_read_hold.sv
hdl/mask_ram_top.sv
tb/mask_ram_tb.sv

// ==== Bender.yml ====
package:
  name: mask_ram

sources:
  # Packages come first, the modules import them
  - hdl/mask_ram_cfg_pkg.sv
  - hdl/mask_ram_op_pkg.sv
  - hdl/mask_ram_req_decode.sv
  - hdl/mask_ram_rmw_ctrl.sv
  - hdl/mask_ram_array.sv
  - hdl/mask_ram_read_hold.sv
  - hdl/mask_ram_top.sv
  - target: simulation
    files:
      - tb/mask_ram_tb.sv
